/* cpu_mem_pkg.sv */
`default_nettype none

package cpu_mem_pkg;

    // access width, 01 reserved and decoded as word
    typedef enum logic [1:0] {
        W_BYTE = 2'b00,
        W_RSVD = 2'b01,
        W_HALF = 2'b10,
        W_WORD = 2'b11
    } mem_width_e;

    // exception codes seen by writeback
    typedef enum logic [6:0] {
        EXC_NONE             = 7'd0,
        EXC_LOAD_MISALIGNED  = 7'd4,
        EXC_STORE_MISALIGNED = 7'd6
    } mem_exc_e;

    // op as handed over by execute
    typedef struct packed {
        logic        valid;
        logic        write;
        logic        unsigned_load;
        mem_width_e  width;
        logic [4:0]  rd;
        logic [31:0] base;
        logic [31:0] imm;
        logic [31:0] wdata;
        // any code from upstream, passed through
        logic [6:0]  exc;
    } exe_mem_op_t;

    // effective address, raw or split into word and byte
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [29:0] word_idx;
            logic [1:0]  byte_off;
        } f;
    } mem_addr_u;

    typedef struct packed {
        logic        write;
        logic        unsigned_load;
        mem_width_e  width;
        logic [4:0]  rd;
        mem_addr_u   addr;
        logic [3:0]  strb;
        // store data already in its byte lanes
        logic [31:0] wdata;
        logic [6:0]  exc;
    } mem_req_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] data;
        logic [6:0]  exc;
    } mem_wb_t;

endpackage

`default_nettype wire

/* apb_pkg.sv */
`default_nettype none

package apb_pkg;

    // master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        // never raised by the sram
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* mem_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_issue (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_mem_pkg::exe_mem_op_t op,
    input  logic                     full,
    output logic                     stall,
    output logic                     push,
    output cpu_mem_pkg::mem_req_t    req
);
    import cpu_mem_pkg::*;

    mem_addr_u  addr;
    logic       misaligned;
    logic [3:0] width_mask;
    logic [6:0] exc;

    // base plus immediate, no translation
    assign addr.raw = op.base + op.imm;

    always_comb begin
        case (op.width)
            W_BYTE: begin
                misaligned = 1'b0;
                width_mask = 4'b0001;
            end
            W_HALF: begin
                // half only needs an even offset
                misaligned = addr.f.byte_off[0];
                width_mask = 4'b0011;
            end
            default: begin
                // word, reserved code too
                misaligned = (addr.f.byte_off != 2'b00);
                width_mask = 4'b1111;
            end
        endcase
    end

    always_comb begin
        // upstream exception wins over our own check
        if (op.exc != EXC_NONE) begin
            exc = op.exc;
        end else if (misaligned) begin
            exc = op.write ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
        end else begin
            exc = EXC_NONE;
        end
    end

    always_comb begin
        req.write         = op.write;
        req.unsigned_load = op.unsigned_load;
        req.width         = op.width;
        req.rd            = op.rd;
        req.addr          = addr;
        // faulted ops carry no strobes
        req.strb          = (exc == EXC_NONE) ? (width_mask << addr.f.byte_off) : 4'b0000;
        // move store data up to its lanes
        req.wdata         = op.wdata << {addr.f.byte_off, 3'b000};
        req.exc           = exc;
    end

    // queue full holds execute
    assign stall = full;
    assign push  = op.valid && !full;

endmodule

`default_nettype wire

/* mem_req_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_req_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  push,
    input  cpu_mem_pkg::mem_req_t push_req,
    input  logic                  pop,
    output cpu_mem_pkg::mem_req_t head,
    output logic                  empty,
    output logic                  full
);
    import cpu_mem_pkg::*;

    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    mem_req_t           mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    // guard against over and underflow
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(QUEUE_DEPTH));
    assign head  = mem[rd_ptr];

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at depth, not at power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* mem_apb_master.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_apb_master (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cpu_mem_pkg::mem_req_t head,
    input  logic                  empty,
    input  apb_pkg::apb_rsp_t     apb_rsp,
    output logic                  pop,
    output apb_pkg::apb_req_t     apb_req,
    output logic                  wb_valid,
    output cpu_mem_pkg::mem_wb_t  wb
);
    import cpu_mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_e;

    state_e      state_q;
    mem_req_t    req_q;
    logic        head_faulted;
    logic        done;
    logic [31:0] rdata_sh;
    logic [31:0] ld_data;

    // one transfer at a time, pop only when idle
    assign pop          = (state_q == ST_IDLE) && !empty;
    assign head_faulted = (head.exc != EXC_NONE);
    assign done         = (state_q == ST_ACCESS) && apb_rsp.pready;

    // bus fields come straight from the latched request
    always_comb begin
        apb_req.psel    = (state_q != ST_IDLE);
        apb_req.penable = (state_q == ST_ACCESS);
        apb_req.pwrite  = req_q.write;
        apb_req.paddr   = req_q.addr.raw;
        apb_req.pwdata  = req_q.wdata;
        // reads drive no strobes
        apb_req.pstrb   = req_q.write ? req_q.strb : 4'b0000;
    end

    // bring the addressed lane down to bit 0
    assign rdata_sh = apb_rsp.prdata >> {req_q.addr.f.byte_off, 3'b000};

    always_comb begin
        case (req_q.width)
            W_BYTE: begin
                ld_data = req_q.unsigned_load ? {24'h0, rdata_sh[7:0]}
                                              : {{24{rdata_sh[7]}}, rdata_sh[7:0]};
            end
            W_HALF: begin
                ld_data = req_q.unsigned_load ? {16'h0, rdata_sh[15:0]}
                                              : {{16{rdata_sh[15]}}, rdata_sh[15:0]};
            end
            default: begin
                ld_data = rdata_sh;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= ST_IDLE;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (!empty) begin
                        // faulted ops skip the bus
                        state_q  <= head_faulted ? ST_IDLE : ST_SETUP;
                        wb_valid <= head_faulted;
                    end
                end
                ST_SETUP: begin
                    state_q <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    // hold here through wait states
                    if (apb_rsp.pready) begin
                        state_q  <= ST_IDLE;
                        wb_valid <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // payload, qualified by state and wb_valid
    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= head;
            if (head_faulted) begin
                wb.rd    <= head.rd;
                wb.rd_we <= 1'b0;
                wb.data  <= 32'h0;
                wb.exc   <= head.exc;
            end
        end
        if (done) begin
            wb.rd    <= req_q.rd;
            // stores write nothing back
            wb.rd_we <= !req_q.write;
            wb.data  <= req_q.write ? 32'h0 : ld_data;
            wb.exc   <= req_q.exc;
        end
    end

endmodule

`default_nettype wire

/* data_sram_apb.sv */
`timescale 1ns/10ps
`default_nettype none

module data_sram_apb #(
    parameter int unsigned MEM_WORDS   = 256,
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic              clk,
    input  logic              arst_n,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp
);
    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int unsigned CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]      mem [MEM_WORDS];
    logic [31:0]      word_addr;
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] wait_cnt;
    logic             access;
    logic             ready;

    // byte address to word, wraps at memory size
    assign word_addr = (apb_req.paddr >> 2) % MEM_WORDS;
    assign idx       = word_addr[IDX_W-1:0];

    assign access = apb_req.psel && apb_req.penable;
    // ready once the wait count is used up
    assign ready  = access && (wait_cnt == CNT_W'(WAIT_STATES));

    assign apb_rsp.pready  = ready;
    assign apb_rsp.prdata  = mem[idx];
    assign apb_rsp.pslverr = 1'b0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (ready) begin
            wait_cnt <= '0;
        end else if (access) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // contents start at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= 32'h0;
            end
        end else if (ready && apb_req.pwrite) begin
            // only strobed bytes change
            for (int b = 0; b < 4; b++) begin
                if (apb_req.pstrb[b]) begin
                    mem[idx][b*8 +: 8] <= apb_req.pwdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* mem_stage_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top #(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter int unsigned MEM_WORDS   = 256,
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_mem_pkg::exe_mem_op_t op,
    output logic                     stall,
    output logic                     wb_valid,
    output cpu_mem_pkg::mem_wb_t     wb
);
    import cpu_mem_pkg::*;
    import apb_pkg::*;

    // issue to queue
    logic     push;
    logic     full;
    mem_req_t req;
    // queue to master
    logic     pop;
    logic     empty;
    mem_req_t head;
    // apb link
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    mem_issue i_issue (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (op),
        .full   (full),
        .stall  (stall),
        .push   (push),
        .req    (req)
    );

    mem_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .push_req (req),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .full     (full)
    );

    mem_apb_master i_master (
        .clk      (clk),
        .arst_n   (arst_n),
        .head     (head),
        .empty    (empty),
        .apb_rsp  (apb_rsp),
        .pop      (pop),
        .apb_req  (apb_req),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    data_sram_apb #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) i_sram (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset low for the first two cycles, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* mem_stage_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage_assertions (
    input logic              clk,
    input logic              arst_n,
    input apb_pkg::apb_req_t apb_req,
    input apb_pkg::apb_rsp_t apb_rsp,
    input logic              pop,
    input logic              wb_valid
);

    // a transfer opens with a setup phase
    a_setup_first: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(apb_req.psel) |-> !apb_req.penable)
        else $error("psel rose together with penable");

    // wait states keep every bus field frozen
    a_access_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (apb_req.psel && apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
        else $error("apb fields changed during a wait state");

    // a popped entry starts a transfer or, when faulted, goes straight to writeback
    a_pop_starts_op: assert property (@(posedge clk) disable iff (!arst_n)
        pop |=> ((apb_req.psel && !apb_req.penable) || wb_valid))
        else $error("pop was followed by neither a setup phase nor a writeback");

endmodule

`default_nettype wire

/* tb_mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;
    import cpu_mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    // 256 words of 4 bytes
    localparam int REF_BYTES      = 1024;

    logic        clk;
    logic        arst_n;
    exe_mem_op_t op;
    logic        stall;
    logic        wb_valid;
    mem_wb_t     wb;

    logic [7:0]  ref_mem [REF_BYTES];
    mem_wb_t     exp_q [$];
    logic [31:0] rng;
    int          value_errors = 0;
    int          timeout_errors = 0;
    int          other_errors = 0;
    int          issued = 0;
    int          wb_count = 0;
    logic        stall_seen = 1'b0;

    tb_clock_gen i_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mem_stage_top i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .op       (op),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    bind mem_apb_master mem_stage_assertions i_assertions (
        .clk      (clk),
        .arst_n   (arst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .pop      (pop),
        .wb_valid (wb_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected writeback of one accepted op, applied to the reference memory
    task automatic predict(input exe_mem_op_t o);
        logic [31:0] addr;
        logic [31:0] val;
        logic [9:0]  bi;
        logic        mis;
        int          nb;
        mem_wb_t     x;
        addr = o.base + o.imm;
        case (o.width)
            W_BYTE:  nb = 1;
            W_HALF:  nb = 2;
            default: nb = 4;
        endcase
        mis = (nb == 2 && addr[0]) || (nb == 4 && addr[1:0] != 2'b00);
        x.rd    = o.rd;
        x.rd_we = 1'b0;
        x.data  = 32'h0;
        // upstream code first, then alignment
        if (o.exc != EXC_NONE) begin
            x.exc = o.exc;
        end else if (mis) begin
            x.exc = o.write ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
        end else begin
            x.exc = EXC_NONE;
        end
        if (x.exc == EXC_NONE) begin
            val = 32'h0;
            // little endian, low byte at the lowest address
            for (int i = 0; i < nb; i++) begin
                bi = addr[9:0] + 10'(i);
                if (o.write) begin
                    ref_mem[bi] = o.wdata[8*i +: 8];
                end else begin
                    val[8*i +: 8] = ref_mem[bi];
                end
            end
            if (!o.write) begin
                if (!o.unsigned_load && nb == 1) begin
                    val = {{24{val[7]}}, val[7:0]};
                end
                if (!o.unsigned_load && nb == 2) begin
                    val = {{16{val[15]}}, val[15:0]};
                end
                x.rd_we = 1'b1;
                x.data  = val;
            end
        end
        exp_q.push_back(x);
    endtask

    // hold the op until stall is low at an edge
    task automatic issue(input logic wr, input logic uns, input logic [1:0] w,
                         input logic [4:0] rd, input logic [31:0] base,
                         input logic [31:0] imm, input logic [31:0] wdata,
                         input logic [6:0] exc);
        int   waited;
        logic taken;
        waited           = 0;
        taken            = 1'b0;
        op.valid         = 1'b1;
        op.write         = wr;
        op.unsigned_load = uns;
        op.width         = mem_width_e'(w);
        op.rd            = rd;
        op.base          = base;
        op.imm           = imm;
        op.wdata         = wdata;
        op.exc           = exc;
        while (!taken && waited < TIMEOUT_CYCLES) begin
            // stall only moves at an edge, so it is settled here
            if (!stall) begin
                taken = 1'b1;
            end else begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        if (taken) begin
            predict(op);
            issued++;
        end else begin
            timeout_errors++;
            $display("timeout: op to address %h was never accepted", base + imm);
        end
        op.valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("timeout: %0d writebacks never arrived", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (arst_n !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            timeout_errors++;
            $display("timeout: reset was never released");
        end
        @(posedge clk);
        #1;
        if (stall !== 1'b0 || wb_valid !== 1'b0) begin
            other_errors++;
            $display("stall or wb_valid is not low after reset");
        end
    endtask

    // word stores, read back through other base and immediate pairs
    task automatic store_load_words();
        logic [31:0] base;
        logic [31:0] imm;
        for (int k = 0; k < 4; k++) begin
            base = 32'h40 + 32'h94 * k;
            imm  = 32'(4 * k) - 32'd8;
            rng  = xorshift32(rng);
            issue(1'b1, 1'b0, W_WORD, 5'd0, base, imm, rng, EXC_NONE);
            issue(1'b0, 1'b0, W_WORD, 5'(k + 1), base + imm + 32'h20, -32'sd32, 32'h0,
                  EXC_NONE);
        end
        drain();
    endtask

    // bytes and halves, with a word load to see the untouched lanes
    task automatic sub_word_lanes();
        issue(1'b1, 1'b0, W_WORD, 5'd0, 32'h80, 32'h0, 32'h1122_3344, EXC_NONE);
        for (int off = 0; off < 4; off++) begin
            rng = xorshift32(rng);
            issue(1'b1, 1'b0, W_BYTE, 5'd0, 32'h80, 32'(off), {rng[31:8], 8'h8c + 8'(off)},
                  EXC_NONE);
            issue(1'b0, 1'b0, W_BYTE, 5'd2, 32'h80, 32'(off), 32'h0, EXC_NONE);
            issue(1'b0, 1'b1, W_BYTE, 5'd3, 32'h80, 32'(off), 32'h0, EXC_NONE);
            issue(1'b0, 1'b0, W_WORD, 5'd4, 32'h80, 32'h0, 32'h0, EXC_NONE);
        end
        for (int off = 0; off < 4; off += 2) begin
            rng = xorshift32(rng);
            issue(1'b1, 1'b0, W_HALF, 5'd0, 32'h88, 32'(off),
                  {rng[31:16], 16'h8001 + 16'(off)}, EXC_NONE);
            issue(1'b0, 1'b0, W_HALF, 5'd5, 32'h88, 32'(off), 32'h0, EXC_NONE);
            issue(1'b0, 1'b1, W_HALF, 5'd6, 32'h88, 32'(off), 32'h0, EXC_NONE);
            issue(1'b0, 1'b0, W_WORD, 5'd7, 32'h88, 32'h0, 32'h0, EXC_NONE);
        end
        drain();
    endtask

    task automatic misaligned_access();
        issue(1'b1, 1'b0, W_WORD, 5'd0, 32'hc0, 32'h0, 32'hcafe_f00d, EXC_NONE);
        issue(1'b1, 1'b0, W_HALF, 5'd0, 32'hc0, 32'h1, 32'h5555_5555, EXC_NONE);
        issue(1'b1, 1'b0, W_WORD, 5'd0, 32'hc0, 32'h2, 32'h6666_6666, EXC_NONE);
        issue(1'b0, 1'b0, W_HALF, 5'd8, 32'hc0, 32'h3, 32'h0, EXC_NONE);
        issue(1'b0, 1'b0, W_WORD, 5'd9, 32'hc0, 32'h1, 32'h0, EXC_NONE);
        issue(1'b0, 1'b0, W_WORD, 5'd10, 32'hc0, 32'h0, 32'h0, EXC_NONE);
        // codes from upstream ride through untouched
        issue(1'b1, 1'b0, W_WORD, 5'd0, 32'hc0, 32'h0, 32'h1234_5678, 7'd2);
        issue(1'b0, 1'b0, W_WORD, 5'd11, 32'hc0, 32'h2, 32'h0, 7'd5);
        issue(1'b0, 1'b1, W_BYTE, 5'd12, 32'hc0, 32'h1, 32'h0, 7'd1);
        issue(1'b0, 1'b0, W_WORD, 5'd13, 32'hc0, 32'h0, 32'h0, EXC_NONE);
        drain();
    endtask

    // twelve ops with no gap, queue must fill
    task automatic back_to_back_burst();
        int start;
        start      = wb_count;
        stall_seen = 1'b0;
        for (int k = 0; k < 12; k++) begin
            rng = xorshift32(rng);
            if (k % 2 == 0) begin
                issue(1'b1, 1'b0, W_WORD, 5'd0, 32'h100, 32'(2 * k), rng, EXC_NONE);
            end else begin
                issue(1'b0, 1'b0, W_WORD, 5'(k), 32'h100, 32'(2 * (k - 1)), 32'h0, EXC_NONE);
            end
        end
        drain();
        if (!stall_seen) begin
            other_errors++;
            $display("stall was never raised during the burst");
        end
        if (wb_count - start != 12) begin
            other_errors++;
            $display("burst gave %0d writebacks instead of 12", wb_count - start);
        end
    endtask

    // small window, mostly aligned, every width code
    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] target;
        logic [31:0] imm;
        logic [1:0]  off;
        for (int n = 0; n < 200; n++) begin
            rng    = xorshift32(rng);
            r      = rng;
            rng    = xorshift32(rng);
            d      = rng;
            off    = (r[7:6] == 2'b00) ? r[1:0] : 2'b00;
            target = 32'h300 + {26'h0, r[5:2], off};
            imm    = {{20{r[19]}}, r[19:8]};
            issue(r[22], r[23], r[21:20], r[28:24], target - imm, imm, d, EXC_NONE);
        end
        drain();
    endtask

    // compare each writeback with the oldest expected record
    always @(negedge clk) begin : wb_monitor
        mem_wb_t want;
        if (arst_n && wb_valid) begin
            wb_count++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("writeback for rd %0d arrived with nothing pending", wb.rd);
            end else begin
                want = exp_q.pop_front();
                if (wb.rd !== want.rd) begin
                    value_errors++;
                    $display("[FAIL] %0t wb.rd got %h expected %h", $time, wb.rd, want.rd);
                end
                if (wb.rd_we !== want.rd_we) begin
                    value_errors++;
                    $display("[FAIL] %0t wb.rd_we got %b expected %b", $time, wb.rd_we,
                             want.rd_we);
                end
                if (wb.data !== want.data) begin
                    value_errors++;
                    $display("[FAIL] %0t wb.data got %h expected %h", $time, wb.data,
                             want.data);
                end
                if (wb.exc !== want.exc) begin
                    value_errors++;
                    $display("[FAIL] %0t wb.exc got %h expected %h", $time, wb.exc, want.exc);
                end
            end
        end
    end

    initial begin
        op  = '0;
        rng = 32'h49592a37;
        for (int i = 0; i < REF_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        wait_reset();
        store_load_words();
        sub_word_lanes();
        misaligned_access();
        back_to_back_burst();
        random_mix();
        if (issued != wb_count) begin
            other_errors++;
            $display("%0d ops issued but %0d writebacks seen", issued, wb_count);
        end
        $display("errors: %0d value, %0d timeout, %0d other", value_errors, timeout_errors,
                 other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
cpu_mem_pkg.sv
apb_pkg.sv
mem_issue.sv
mem_req_queue.sv
mem_apb_master.sv
data_sram_apb.sv
mem_stage_top.sv
tb_clock_gen.sv
mem_stage_assertions.sv
tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f all.f \
        --top-module tb_mem_stage -o tb_mem_stage; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/tb_mem_stage > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation ended with an error status"
    exit 1
fi

cat "$LOG"

if grep -qx "TESTS PASSED" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
